/* Makefile */
TOP := id_stage_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f project.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/id_stage_asserts.sv */
// concurrent checks on the decode stage issue handshake and branch redirect

`timescale 1ns/1ps

module id_stage_asserts import id_width_pkg::*; (
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_es_allowin,
  input logic      i_ds_to_es_valid,
  input logic      i_ds_valid,
  input logic      i_es_load,
  input reg_addr_t i_es_byp_rd,
  input inst_t     i_ds_inst,
  input logic      i_br_taken,
  input pc_t       i_br_target
);

  logic issue;
  logic hazard;
  logic can_issue;

  // load-use match on the raw source fields of the held instruction
  assign hazard    = i_es_load && (i_es_byp_rd != '0) &&
                     (i_es_byp_rd == i_ds_inst[19:15] || i_es_byp_rd == i_ds_inst[24:20]);
  assign issue     = i_ds_to_es_valid && i_es_allowin;
  assign can_issue = i_ds_valid && !hazard && i_es_allowin;

  a_issue_no_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    issue |-> can_issue)
    else $error("issue while the load-use stall is high");

  a_taken_on_issue: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> can_issue)
    else $error("branch taken without an issue");

  // targets are at least halfword aligned
  a_target_even: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> !i_br_target[0])
    else $error("odd branch target");

endmodule

bind id_stage id_stage_asserts u_asserts (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_es_allowin     (i_es_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_valid       (ds_valid),
  .i_es_load        (i_es_load),
  .i_es_byp_rd      (i_es_byp_rd),
  .i_ds_inst        (ds_inst),
  .i_br_taken       (o_br_taken),
  .i_br_target      (o_br_target)
);

/* dv/id_stage_tb.sv */
// decode stage testbench: clock, reset, random stimulus, reference model, scoreboard and compares

`timescale 1ns/1ps

module id_stage_tb import id_width_pkg::*, rv_isa_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int RANDOM_CYCLES = 4000;
  localparam int HOLD_LIMIT    = 200;  // cycles an instruction may sit unissued
  localparam int DRAIN_LIMIT   = 50;

  logic      i_clk, i_rst_n;
  logic      i_fs_to_ds_valid, i_es_allowin, i_ws_gpr_wen, i_es_load;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc;
  reg_addr_t i_ws_gpr_waddr, i_es_byp_rd, i_ms_byp_rd, i_ws_byp_rd;
  xlen_t     i_ws_gpr_wdata, i_es_byp_data, i_ms_byp_data, i_ws_byp_data;
  logic      o_ds_allowin, o_ds_to_es_valid;
  pc_t       o_es_pc, o_br_target;
  xlen_t     o_es_rs1_data, o_es_rs2_data, o_es_imm;
  reg_addr_t o_es_rd;
  alu_op_t   o_es_alu_op;
  src1_sel_t o_es_src1_sel;
  src2_sel_t o_es_src2_sel;
  logic      o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_invalid, o_br_taken;

  integer    seed;
  int        value_errs, timeout_errs, issued, hold_cycles;
  inst_t     inst_q[$];  // at most one entry, the instruction held in decode
  pc_t       pc_q[$];
  xlen_t     shadow [0:31];

  // expected decode of the held instruction
  reg_addr_t e_rs1, e_rs2, e_rd;
  xlen_t     e_imm;
  alu_op_t   e_alu;
  src1_sel_t e_src1;
  src2_sel_t e_src2;
  br_func_t  e_bfn;
  logic      e_wen, e_ren, e_mwen, e_inv, e_br, e_jal, e_jalr;

  id_stage UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  task automatic check_xlen(input string name, input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_pc(input string name, input pc_t act, input pc_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t act, input reg_addr_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_alu(input string name, input alu_op_t act, input alu_op_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_src2(input string name, input src2_sel_t act, input src2_sel_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, act, exp);
    end
  endtask

  function automatic alu_op_t alu_expected(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  task automatic decode_expected(input inst_t inst);
    logic [2:0] f3;
    logic [5:0] hi6;
    logic       ok;
    f3     = inst[14:12];
    hi6    = inst[31:26];
    e_rs1  = inst[19:15];
    e_rs2  = inst[24:20];
    e_rd   = inst[11:7];
    e_bfn  = f3;
    e_imm  = '0;
    e_alu  = ALU_ADD;
    e_src1 = SRC1_RS1;
    e_src2 = SRC2_RS2;
    {e_wen, e_ren, e_mwen, e_br, e_jal, e_jalr} = '0;
    ok = 1'b0;
    case (inst[6:0])
      OPC_LUI, OPC_AUIPC: begin
        ok     = 1'b1;
        e_wen  = 1'b1;
        e_imm  = {{32{inst[31]}}, inst[31:12], 12'h000};
        e_src2 = SRC2_IMM;
        e_alu  = (inst[6:0] == OPC_LUI) ? ALU_COPY2 : ALU_ADD;
        e_src1 = (inst[6:0] == OPC_LUI) ? SRC1_RS1 : SRC1_PC;
      end
      OPC_OP_IMM: begin
        // rv64 shamt is 6 bits, only srai may set bit 30
        ok = (f3 == 3'b001) ? (hi6 == 6'd0) :
             (f3 == 3'b101) ? (hi6 == 6'd0 || hi6 == 6'b010000) : 1'b1;
        e_wen  = 1'b1;
        e_imm  = {{52{inst[31]}}, inst[31:20]};
        e_src2 = SRC2_IMM;
        e_alu  = alu_expected(f3, f3 == 3'b101 && inst[30]);
      end
      OPC_OP: begin
        ok = inst[31:25] == 7'd0 ||
             (inst[31:25] == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
        e_wen = 1'b1;
        e_alu = alu_expected(f3, inst[30]);
      end
      OPC_LOAD, OPC_STORE: begin
        ok     = (f3 == 3'b011);  // doubleword only
        e_ren  = !inst[5];
        e_wen  = !inst[5];
        e_mwen = inst[5];
        e_imm  = inst[5] ? {{52{inst[31]}}, inst[31:25], inst[11:7]}
                         : {{52{inst[31]}}, inst[31:20]};
        e_src2 = SRC2_IMM;
      end
      OPC_BRANCH: begin
        ok    = (f3[2:1] != 2'b01);
        e_br  = 1'b1;
        e_imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_JAL, OPC_JALR: begin
        ok     = inst[3] || f3 == 3'b000;  // bit 3 tells jal from jalr
        e_jal  = inst[3];
        e_jalr = !inst[3];
        e_wen  = 1'b1;
        e_imm  = inst[3] ? {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}
                         : {{52{inst[31]}}, inst[31:20]};
        e_src1 = SRC1_PC;
        e_src2 = SRC2_FOUR;
      end
      default: ;
    endcase
    e_inv = !ok;
    if (!ok) begin
      {e_wen, e_ren, e_mwen, e_br, e_jal, e_jalr} = '0;
    end
    if (e_rd == '0) begin
      e_wen = 1'b0;
    end
  endtask

  // newest stage first, then the register file
  function automatic xlen_t operand_expected(input reg_addr_t rs);
    if (rs == '0) return '0;
    if (i_es_byp_rd == rs) return i_es_byp_data;
    if (i_ms_byp_rd == rs) return i_ms_byp_data;
    if (i_ws_byp_rd == rs) return i_ws_byp_data;
    return shadow[rs];
  endfunction

  function automatic logic branch_cond(input br_func_t f, input xlen_t a, input xlen_t b);
    case (f)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      BR_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic xlen_t rand_xlen();
    logic [31:0] hi, lo;
    hi = $random(seed);
    lo = $random(seed);
    case (hi[31:30])
      2'b00:   return {62'd0, lo[1:0]};  // small values give equal operands
      2'b01:   return {64{lo[0]}};
      default: return {hi, lo};
    endcase
  endfunction

  function automatic inst_t random_inst();
    logic [31:0] r, k;
    inst_t       inst;
    r    = $random(seed);
    k    = $random(seed);
    inst = r;
    case (k[3:0])
      4'd0:              inst[6:0] = OPC_LUI;
      4'd1:              inst[6:0] = OPC_AUIPC;
      4'd2, 4'd3:        inst[6:0] = OPC_OP_IMM;
      4'd4, 4'd5:        inst[6:0] = OPC_OP;
      4'd6:              inst[6:0] = OPC_LOAD;
      4'd7:              inst[6:0] = OPC_STORE;
      4'd8, 4'd9, 4'd10: inst[6:0] = OPC_BRANCH;
      4'd11:             inst[6:0] = OPC_JAL;
      4'd12:             inst[6:0] = OPC_JALR;
      default:           inst[6:0] = k[10:4];  // mostly outside the subset
    endcase
    // registers x0..x7 only, so bypass and stall hits are frequent
    inst[11:10] = 2'b00;
    inst[19:18] = 2'b00;
    inst[24:23] = 2'b00;
    if (k[14:12] != 3'b000) begin  // 1 in 8 keeps raw funct fields
      case (inst[6:0])
        OPC_OP:              inst[31:25] = {1'b0, inst[30], 5'b00000};
        OPC_LOAD, OPC_STORE: inst[14:12] = 3'b011;
        OPC_JALR:            inst[14:12] = 3'b000;
        OPC_OP_IMM: begin
          if (inst[13:12] == 2'b01) begin
            inst[31:26] = {1'b0, inst[30] & inst[14], 4'b0000};
          end
        end
        OPC_BRANCH: begin
          if (inst[14:13] == 2'b01) begin
            inst[13] = 1'b0;
          end
        end
        default: ;
      endcase
    end
    return inst;
  endfunction

  task automatic drive_random();
    logic [31:0] r, p, q;
    r = $random(seed);
    p = $random(seed);
    q = $random(seed);
    i_fs_to_ds_valid = r[0] | r[1];
    i_es_allowin     = r[2] | r[3];
    i_es_load        = (r[5:4] == 2'b00);
    i_ws_gpr_wen     = r[6];
    i_ws_gpr_waddr   = {2'b00, r[9:7]};
    i_es_byp_rd      = {2'b00, r[12:10]};
    i_ms_byp_rd      = {2'b00, r[15:13]};
    i_ws_byp_rd      = {2'b00, r[18:16]};
    i_fs_inst        = random_inst();
    i_fs_pc          = {p, q[31:2], 2'b00};  // word aligned
    i_ws_gpr_wdata   = rand_xlen();
    i_es_byp_data    = rand_xlen();
    i_ms_byp_data    = rand_xlen();
    i_ws_byp_data    = rand_xlen();
  endtask

  // runs between drive and the next rising edge, outputs are settled
  task automatic sample_and_compare();
    logic  stall, exp_valid, exp_allowin, issue, exp_taken;
    xlen_t a, b;
    pc_t   exp_target;
    stall = 1'b0;
    if (inst_q.size() > 0) begin
      decode_expected(inst_q[0]);
      stall = i_es_load && i_es_byp_rd != '0 &&
              (i_es_byp_rd == e_rs1 || i_es_byp_rd == e_rs2);
    end
    exp_valid   = inst_q.size() > 0 && !stall;
    exp_allowin = inst_q.size() == 0 || (!stall && i_es_allowin);
    issue       = exp_valid && i_es_allowin;
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, exp_valid);
    check_bit("o_ds_allowin", o_ds_allowin, exp_allowin);
    if (issue) begin
      a = operand_expected(e_rs1);
      b = operand_expected(e_rs2);
      check_pc("o_es_pc", o_es_pc, pc_q[0]);
      check_xlen("o_es_rs1_data", o_es_rs1_data, a);
      check_xlen("o_es_rs2_data", o_es_rs2_data, b);
      check_addr("o_es_rd", o_es_rd, e_rd);
      check_bit("o_es_invalid", o_es_invalid, e_inv);
      check_bit("o_es_gpr_wen", o_es_gpr_wen, e_wen);
      check_bit("o_es_mem_ren", o_es_mem_ren, e_ren);
      check_bit("o_es_mem_wen", o_es_mem_wen, e_mwen);
      if (!e_inv) begin
        check_xlen("o_es_imm", o_es_imm, e_imm);
        check_alu("o_es_alu_op", o_es_alu_op, e_alu);
        check_bit("o_es_src1_sel", o_es_src1_sel, e_src1);
        check_src2("o_es_src2_sel", o_es_src2_sel, e_src2);
      end
      exp_taken = e_jal || e_jalr || (e_br && branch_cond(e_bfn, a, b));
      check_bit("o_br_taken", o_br_taken, exp_taken);
      if (exp_taken) begin
        exp_target = e_jalr ? ((a + e_imm) & ~64'd1) : pc_q[0] + e_imm;
        check_pc("o_br_target", o_br_target, exp_target);
      end
      void'(inst_q.pop_front());
      void'(pc_q.pop_front());
      hold_cycles = 0;
      issued++;
    end else begin
      check_bit("o_br_taken", o_br_taken, 1'b0);
      if (inst_q.size() > 0) begin
        hold_cycles++;
      end
      if (hold_cycles == HOLD_LIMIT) begin
        timeout_errs++;
        $display("timeout: instruction at pc %h not issued after %0d cycles",
                 pc_q[0], HOLD_LIMIT);
      end
    end
    if (i_fs_to_ds_valid && exp_allowin) begin
      inst_q.push_back(i_fs_inst);
      pc_q.push_back(i_fs_pc);
    end
    if (i_ws_gpr_wen && i_ws_gpr_waddr != '0) begin
      shadow[i_ws_gpr_waddr] = i_ws_gpr_wdata;  // visible after this edge
    end
  endtask

  task automatic step_cycle(input logic drain);
    @(negedge i_clk);
    drive_random();
    if (drain) begin
      i_fs_to_ds_valid = 1'b0;
      i_es_allowin     = 1'b1;
      i_es_load        = 1'b0;
    end
    #(CLK_PERIOD/4);
    sample_and_compare();
  endtask

  initial begin
    seed         = 32'h5d48_d063;
    value_errs   = 0;
    timeout_errs = 0;
    issued       = 0;
    hold_cycles  = 0;
    shadow       = '{default: '0};
    i_rst_n      = 1'b0;
    drive_random();
    i_fs_to_ds_valid = 1'b0;
    i_ws_gpr_wen     = 1'b0;
    repeat (RESET_CYCLES) @(negedge i_clk);
    check_bit("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_bit("o_br_taken", o_br_taken, 1'b0);
    check_bit("o_ds_allowin", o_ds_allowin, 1'b1);
    i_rst_n = 1'b1;

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      step_cycle(1'b0);
    end
    // empty the stage with execute always ready
    for (int c = 0; c < DRAIN_LIMIT && inst_q.size() > 0; c++) begin
      step_cycle(1'b1);
    end
    if (inst_q.size() > 0) begin
      timeout_errs++;
      $display("timeout: drain ended with %0d instruction(s) never issued", inst_q.size());
    end

    $display("issued %0d, value errors %0d, timeout errors %0d",
             issued, value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* logic/id_branch_unit.sv */
// branch condition evaluation and branch / jal / jalr target computation

`timescale 1ns/1ps

module id_branch_unit import id_width_pkg::*, rv_isa_pkg::*; (
  input  pc_t       i_pc,
  input  xlen_t     i_rs1_data,
  input  xlen_t     i_rs2_data,
  input  xlen_t     i_imm,
  input  logic      i_is_branch,
  input  logic      i_is_jal,
  input  logic      i_is_jalr,
  input  br_func_t  i_br_func,
  output logic      o_taken,
  output pc_t       o_target
);

  logic  eq, lt_s, lt_u;
  logic  cond;
  xlen_t jalr_sum;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt_s;
      BR_BGE:  cond = !lt_s;
      BR_BLTU: cond = lt_u;
      BR_BGEU: cond = !lt_u;
      default: cond = 1'b0;  // reserved funct3, decoder flags it
    endcase
  end

  assign o_taken = i_is_jal || i_is_jalr || (i_is_branch && cond);

  assign jalr_sum = i_rs1_data + i_imm;
  assign o_target = i_is_jalr ? {jalr_sum[XLEN-1:1], 1'b0}  // lsb cleared per spec
                              : i_pc + i_imm;

endmodule

/* logic/id_decoder.sv */
// combinational rv64i subset decoder: register fields, immediates, alu and memory controls

`timescale 1ns/1ps

module id_decoder import id_width_pkg::*, rv_isa_pkg::*; (
  input  inst_t      i_inst,
  output reg_addr_t  o_rs1,
  output reg_addr_t  o_rs2,
  output reg_addr_t  o_rd,
  output xlen_t      o_imm,
  output alu_op_t    o_alu_op,
  output src1_sel_t  o_src1_sel,
  output src2_sel_t  o_src2_sel,
  output logic       o_gpr_wen,
  output logic       o_mem_ren,
  output logic       o_mem_wen,
  output logic       o_is_branch,
  output logic       o_is_jal,
  output logic       o_is_jalr,
  output br_func_t   o_br_func,
  output logic       o_invalid
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       shamt_ok;     // rv64 shifts carry a 6-bit shamt
  logic       op_ok;
  logic       gpr_wen_raw;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign funct6 = i_inst[31:26];

  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = i_inst[11:7];
  assign o_br_func = funct3;

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign shamt_ok = (funct3 == F3_SLL)     ? (funct6 == F6_BASE) :
                    (funct3 == F3_SRL_SRA) ? (funct6 == F6_BASE || funct6 == F6_ALT) :
                                             1'b1;
  assign op_ok    = (funct7 == F7_BASE) ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

  // shared by op and op-imm, alt selects sub / sra
  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: alu_from_f3 = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_from_f3 = ALU_SLL;
      F3_SLT:     alu_from_f3 = ALU_SLT;
      F3_SLTU:    alu_from_f3 = ALU_SLTU;
      F3_XOR:     alu_from_f3 = ALU_XOR;
      F3_SRL_SRA: alu_from_f3 = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_from_f3 = ALU_OR;
      default:    alu_from_f3 = ALU_AND;
    endcase
  endfunction

  always_comb begin
    // anything not matched below stays invalid with no writes
    o_imm       = '0;
    o_alu_op    = ALU_ADD;
    o_src1_sel  = SRC1_RS1;
    o_src2_sel  = SRC2_RS2;
    gpr_wen_raw = 1'b0;
    o_mem_ren   = 1'b0;
    o_mem_wen   = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_invalid   = 1'b1;
    case (opcode)
      OPC_LUI: begin
        o_imm = imm_u; o_src2_sel = SRC2_IMM; o_alu_op = ALU_COPY2;
        gpr_wen_raw = 1'b1; o_invalid = 1'b0;
      end
      OPC_AUIPC: begin
        o_imm = imm_u; o_src1_sel = SRC1_PC; o_src2_sel = SRC2_IMM;
        gpr_wen_raw = 1'b1; o_invalid = 1'b0;
      end
      OPC_OP_IMM: if (shamt_ok) begin
        o_imm       = imm_i;
        o_src2_sel  = SRC2_IMM;
        o_alu_op    = alu_from_f3(funct3, i_inst[30] && funct3 == F3_SRL_SRA);  // no subi
        gpr_wen_raw = 1'b1;
        o_invalid   = 1'b0;
      end
      OPC_OP: if (op_ok) begin
        o_alu_op    = alu_from_f3(funct3, i_inst[30]);
        gpr_wen_raw = 1'b1;
        o_invalid   = 1'b0;
      end
      OPC_LOAD: if (funct3 == F3_DWORD) begin
        o_imm = imm_i; o_src2_sel = SRC2_IMM;  // address = rs1 + imm
        o_mem_ren = 1'b1; gpr_wen_raw = 1'b1; o_invalid = 1'b0;
      end
      OPC_STORE: if (funct3 == F3_DWORD) begin
        o_imm = imm_s; o_src2_sel = SRC2_IMM;
        o_mem_wen = 1'b1; o_invalid = 1'b0;
      end
      OPC_BRANCH: if (funct3 != 3'b010 && funct3 != 3'b011) begin
        o_imm = imm_b; o_is_branch = 1'b1; o_invalid = 1'b0;
      end
      OPC_JAL: begin
        o_imm = imm_j; o_src1_sel = SRC1_PC; o_src2_sel = SRC2_FOUR;
        o_is_jal = 1'b1; gpr_wen_raw = 1'b1; o_invalid = 1'b0;
      end
      OPC_JALR: if (funct3 == F3_JALR) begin
        o_imm = imm_i; o_src1_sel = SRC1_PC; o_src2_sel = SRC2_FOUR;
        o_is_jalr = 1'b1; gpr_wen_raw = 1'b1; o_invalid = 1'b0;
      end
      default: ;
    endcase
  end

  assign o_gpr_wen = gpr_wen_raw && (o_rd != '0);  // x0 writes dropped here

endmodule

/* logic/id_gpr_file.sv */
// 32-entry general register file, two combinational read ports and one write port

`timescale 1ns/1ps

module id_gpr_file import id_width_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  reg_addr_t  i_raddr1,
  input  reg_addr_t  i_raddr2,
  input  logic       i_wen,
  input  reg_addr_t  i_waddr,
  input  xlen_t      i_wdata,
  output xlen_t      o_rdata1,
  output xlen_t      o_rdata2
);

  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write not seen here, wb bypass covers it
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* logic/id_operand_bypass.sv */
// source operand forwarding from execute, memory and writeback, plus load-use stall

`timescale 1ns/1ps

module id_operand_bypass import id_width_pkg::*; (
  input  reg_addr_t  i_rs1,
  input  reg_addr_t  i_rs2,
  input  xlen_t      i_rf_rdata1,
  input  xlen_t      i_rf_rdata2,
  input  reg_addr_t  i_es_byp_rd,
  input  xlen_t      i_es_byp_data,
  input  reg_addr_t  i_ms_byp_rd,
  input  xlen_t      i_ms_byp_data,
  input  reg_addr_t  i_ws_byp_rd,
  input  xlen_t      i_ws_byp_data,
  input  logic       i_es_load,
  output xlen_t      o_rs1_data,
  output xlen_t      o_rs2_data,
  output logic       o_load_stall
);

  // newest producer wins, index 0 never forwards
  function automatic xlen_t pick(input reg_addr_t rs, input xlen_t rf_data);
    if (i_es_byp_rd != '0 && i_es_byp_rd == rs) begin
      pick = i_es_byp_data;
    end else if (i_ms_byp_rd != '0 && i_ms_byp_rd == rs) begin
      pick = i_ms_byp_data;
    end else if (i_ws_byp_rd != '0 && i_ws_byp_rd == rs) begin
      pick = i_ws_byp_data;
    end else begin
      pick = rf_data;
    end
  endfunction

  always_comb begin
    o_rs1_data = pick(i_rs1, i_rf_rdata1);
    o_rs2_data = pick(i_rs2, i_rf_rdata2);
  end

  // load data not ready until the load leaves execute
  // both fields compared even if unused by the instruction
  assign o_load_stall = i_es_load && (i_es_byp_rd != '0) &&
                        (i_es_byp_rd == i_rs1 || i_es_byp_rd == i_rs2);

endmodule

/* logic/id_stage.sv */
// decode stage top: fetch pipeline register, valid/allowin control, decode and operand wiring

`timescale 1ns/1ps

module id_stage import id_width_pkg::*, rv_isa_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  // fetch handshake
  input  logic       i_fs_to_ds_valid,
  input  inst_t      i_fs_inst,
  input  pc_t        i_fs_pc,
  output logic       o_ds_allowin,
  // execute handshake
  input  logic       i_es_allowin,
  output logic       o_ds_to_es_valid,
  // writeback port into the register file
  input  logic       i_ws_gpr_wen,
  input  reg_addr_t  i_ws_gpr_waddr,
  input  xlen_t      i_ws_gpr_wdata,
  // forwarding
  input  reg_addr_t  i_es_byp_rd,
  input  xlen_t      i_es_byp_data,
  input  reg_addr_t  i_ms_byp_rd,
  input  xlen_t      i_ms_byp_data,
  input  reg_addr_t  i_ws_byp_rd,
  input  xlen_t      i_ws_byp_data,
  input  logic       i_es_load,
  // decoded fields to execute
  output pc_t        o_es_pc,
  output xlen_t      o_es_rs1_data,
  output xlen_t      o_es_rs2_data,
  output xlen_t      o_es_imm,
  output reg_addr_t  o_es_rd,
  output alu_op_t    o_es_alu_op,
  output src1_sel_t  o_es_src1_sel,
  output src2_sel_t  o_es_src2_sel,
  output logic       o_es_gpr_wen,
  output logic       o_es_mem_ren,
  output logic       o_es_mem_wen,
  output logic       o_es_invalid,
  // redirect to fetch
  output logic       o_br_taken,
  output pc_t        o_br_target
);

  logic      ds_valid;
  inst_t     ds_inst;
  pc_t       ds_pc;
  logic      fs_to_ds_fire;
  logic      ds_issue;
  logic      load_stall;

  reg_addr_t rs1, rs2;
  xlen_t     rf_rdata1, rf_rdata2;
  logic      is_branch, is_jal, is_jalr;
  br_func_t  br_func;
  logic      br_taken;

  assign o_ds_allowin     = !ds_valid || (!load_stall && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && !load_stall;
  assign fs_to_ds_fire    = i_fs_to_ds_valid && o_ds_allowin;
  assign ds_issue         = o_ds_to_es_valid && i_es_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (fs_to_ds_fire) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  assign o_es_pc = ds_pc;

  id_decoder u_decoder (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_es_rd),
    .o_imm       (o_es_imm),
    .o_alu_op    (o_es_alu_op),
    .o_src1_sel  (o_es_src1_sel),
    .o_src2_sel  (o_es_src2_sel),
    .o_gpr_wen   (o_es_gpr_wen),
    .o_mem_ren   (o_es_mem_ren),
    .o_mem_wen   (o_es_mem_wen),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_br_func   (br_func),
    .o_invalid   (o_es_invalid)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_byp_rd   (i_es_byp_rd),
    .i_es_byp_data (i_es_byp_data),
    .i_ms_byp_rd   (i_ms_byp_rd),
    .i_ms_byp_data (i_ms_byp_data),
    .i_ws_byp_rd   (i_ws_byp_rd),
    .i_ws_byp_data (i_ws_byp_data),
    .i_es_load     (i_es_load),
    .o_rs1_data    (o_es_rs1_data),
    .o_rs2_data    (o_es_rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch (
    .i_pc        (ds_pc),
    .i_rs1_data  (o_es_rs1_data),  // forwarded values
    .i_rs2_data  (o_es_rs2_data),
    .i_imm       (o_es_imm),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_br_func   (br_func),
    .o_taken     (br_taken),
    .o_target    (o_br_target)
  );

  // redirect only on the issue cycle so fetch never acts on a stalled branch
  assign o_br_taken = br_taken && ds_issue;

endmodule

/* logic/id_width_pkg.sv */
// data, address, instruction and register index widths with their vector types

package id_width_pkg;

  localparam int XLEN       = 64;  // register data width
  localparam int PC_W       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;   // 32 architectural registers

  // operands, immediates, results
  typedef logic [XLEN-1:0] xlen_t;

  // instruction address
  typedef logic [PC_W-1:0] pc_t;

  // raw instruction word from fetch
  typedef logic [INST_W-1:0] inst_t;

  // register index, x0 hardwired to zero
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

/* logic/rv_isa_pkg.sv */
// rv64i opcode and funct constants, alu op codes, branch functions, operand selects

package rv_isa_pkg;

  // major opcodes of the decoded subset
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_DWORD   = 3'b011;  // ld / sd
  localparam logic [2:0] F3_JALR    = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra
  localparam logic [5:0] F6_BASE = 6'b000000;   // rv64 shift-immediate
  localparam logic [5:0] F6_ALT  = 6'b010000;

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_COPY2 = 4'd10;  // result = operand 2, for lui

  // same encoding as funct3 of a branch
  typedef logic [2:0] br_func_t;
  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

  typedef logic src1_sel_t;
  localparam src1_sel_t SRC1_RS1 = 1'b0;
  localparam src1_sel_t SRC1_PC  = 1'b1;

  typedef logic [1:0] src2_sel_t;
  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2;  // link value pc + 4

endpackage

/* project.f */
logic/id_width_pkg.sv
logic/rv_isa_pkg.sv
logic/id_decoder.sv
logic/id_gpr_file.sv
logic/id_operand_bypass.sv
logic/id_branch_unit.sv
logic/id_stage.sv
dv/id_stage_asserts.sv
dv/id_stage_tb.sv
